// ==== aluStage.sv ====
`include "execStage_cfg.svh"

module aluStage
(
	input  logic              clk,
	input  logic              reset,
	input  logic              inValid,
	input  execPkg::opKey     op,
	input  execPkg::regAddr   regC,
	input  execPkg::regAddr   regB,
	input  execPkg::word      aluIn1,
	input  execPkg::word      aluIn2,
	input  logic              condMet,
	output logic              outValid,
	output execPkg::word      result,
	output execPkg::regAddr   destReg,
	output logic              regWrite,
	output execPkg::condFlags flags,
	output logic              flagWrite
);

	logic [`WORD_WIDTH:0] sum; // extra bit is the carry out
	logic                 nandOp;
	logic                 adiOp;
	execPkg::word         aluOut;
	execPkg::condFlags    aluFlags;

	assign sum    = {1'b0, aluIn1} + {1'b0, aluIn2};
	assign nandOp = op inside {execPkg::NDU, execPkg::NDC, execPkg::NDZ};
	assign adiOp  = ({op[5:2], 2'b00} == execPkg::ADI);
	assign aluOut = nandOp ? ~(aluIn1 & aluIn2) : sum[`WORD_WIDTH-1:0];

	assign aluFlags.zero  = (aluOut == '0);
	assign aluFlags.carry = nandOp ? 1'b0 : sum[`WORD_WIDTH];

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			outValid  <= 1'b0;
			regWrite  <= 1'b0;
			flagWrite <= 1'b0;
		end
		else
		begin
			outValid  <= inValid;
			regWrite  <= inValid && condMet; // failed condition squashes both writes
			flagWrite <= inValid && condMet;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			result  <= '0;
			flags   <= '0;
			destReg <= '0;
		end
		else if (inValid)
		begin
			result  <= aluOut;
			flags   <= aluFlags;
			destReg <= adiOp ? regB : regC;
		end
	end

endmodule

// ==== compile.f ====
+incdir+.
execPkg.sv
destDecode.sv
hazardUnit.sv
operandSelect.sv
flagUnit.sv
aluStage.sv
execStage.sv
execStage_tb.sv

// ==== destDecode.sv ====
module destDecode
(
	input  execPkg::opKey   op,
	input  execPkg::regAddr regA,
	input  execPkg::regAddr regB,
	input  execPkg::regAddr regC,
	output execPkg::regAddr dest,
	output logic            writesReg
);

	always_comb
	begin
		case (op)
			execPkg::ADD, execPkg::ADC, execPkg::ADZ,
			execPkg::NDU, execPkg::NDC, execPkg::NDZ:
			begin
				dest      = regC; // R-type writes rc
				writesReg = 1'b1;
			end
			execPkg::LHI, execPkg::LW, execPkg::LM, execPkg::JAL:
			begin
				dest      = regA; // loads and link write ra
				writesReg = 1'b1;
			end
			default:
			begin
				// only ADI is left with a destination, in rb
				dest      = regB;
				writesReg = ({op[5:2], 2'b00} == execPkg::ADI);
			end
		endcase
	end

endmodule

// ==== execPkg.sv ====
`include "execStage_cfg.svh"

package execPkg;

	typedef logic [`WORD_WIDTH-1:0] word;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr;

	// opcode key is {instr[15:12], instr[1:0]}
	typedef enum logic [`OP_KEY_WIDTH-1:0]
	{
		ADD = 6'b000000,
		ADZ = 6'b000001, // executes on zero
		ADC = 6'b000010, // executes on carry
		ADI = 6'b000100, // low two bits are immediate, match on [5:2]
		NDU = 6'b001000,
		NDZ = 6'b001001,
		NDC = 6'b001010,
		LHI = 6'b001100,
		LW  = 6'b010000,
		SW  = 6'b010100,
		LM  = 6'b011000,
		JAL = 6'b100000,
		JLR = 6'b100100
	} opKey;

	// zero in the upper bit, carry in the lower
	typedef struct packed
	{
		logic zero;
		logic carry;
	} condFlags;

	// operand source for each ALU input
	typedef enum logic [1:0]
	{
		fromReg   = 2'b00,
		fromExMem = 2'b01,
		fromMemWb = 2'b10
	} fwdSel;

endpackage

// ==== execStage.sv ====
module execStage
(
	input  logic              clk,
	input  logic              reset,
	input  logic              inValid,
	input  execPkg::opKey     op,
	input  execPkg::regAddr   regA,
	input  execPkg::regAddr   regB,
	input  execPkg::regAddr   regC,
	input  execPkg::word      rfData1,
	input  execPkg::word      rfData2,
	input  execPkg::word      imm,
	input  logic              exMemValid,
	input  execPkg::opKey     exMemOp,
	input  execPkg::regAddr   exMemRegA,
	input  execPkg::regAddr   exMemRegB,
	input  execPkg::regAddr   exMemRegC,
	input  logic              exMemExecuted,
	input  execPkg::word      exMemResult,
	input  logic              exMemFlagWrite,
	input  execPkg::condFlags exMemFlags,
	input  logic              memWbValid,
	input  execPkg::opKey     memWbOp,
	input  execPkg::regAddr   memWbRegA,
	input  execPkg::regAddr   memWbRegB,
	input  execPkg::regAddr   memWbRegC,
	input  logic              memWbExecuted,
	input  execPkg::word      memWbResult,
	input  logic              memWbFlagWrite,
	input  execPkg::condFlags memWbFlags,
	input  logic              ccrWrite,
	input  execPkg::condFlags ccrValue,
	output logic              outValid,
	output execPkg::word      result,
	output execPkg::regAddr   destReg,
	output logic              regWrite,
	output execPkg::condFlags flags,
	output logic              flagWrite,
	output execPkg::condFlags ccr
);

	execPkg::fwdSel sel1;
	execPkg::fwdSel sel2;
	logic           useImm;
	execPkg::word   aluIn1;
	execPkg::word   aluIn2;
	logic           condMet;

	hazardUnit hazardUnit_inst
	(
		.op(op),
		.regA(regA),
		.regB(regB),
		.exMemValid(exMemValid),
		.exMemExecuted(exMemExecuted),
		.exMemOp(exMemOp),
		.exMemRegA(exMemRegA),
		.exMemRegB(exMemRegB),
		.exMemRegC(exMemRegC),
		.memWbValid(memWbValid),
		.memWbExecuted(memWbExecuted),
		.memWbOp(memWbOp),
		.memWbRegA(memWbRegA),
		.memWbRegB(memWbRegB),
		.memWbRegC(memWbRegC),
		.sel1(sel1),
		.sel2(sel2),
		.useImm(useImm)
	);

	operandSelect operandSelect_inst
	(
		.rfData1(rfData1),
		.rfData2(rfData2),
		.imm(imm),
		.exMemResult(exMemResult),
		.memWbResult(memWbResult),
		.sel1(sel1),
		.sel2(sel2),
		.useImm(useImm),
		.aluIn1(aluIn1),
		.aluIn2(aluIn2)
	);

	flagUnit flagUnit_inst
	(
		.clk(clk),
		.reset(reset),
		.op(op),
		.ccrWrite(ccrWrite),
		.ccrValue(ccrValue),
		.exMemValid(exMemValid),
		.exMemFlagWrite(exMemFlagWrite),
		.exMemFlags(exMemFlags),
		.memWbValid(memWbValid),
		.memWbFlagWrite(memWbFlagWrite),
		.memWbFlags(memWbFlags),
		.ccr(ccr),
		.condMet(condMet)
	);

	aluStage aluStage_inst
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.op(op),
		.regC(regC),
		.regB(regB),
		.aluIn1(aluIn1),
		.aluIn2(aluIn2),
		.condMet(condMet),
		.outValid(outValid),
		.result(result),
		.destReg(destReg),
		.regWrite(regWrite),
		.flags(flags),
		.flagWrite(flagWrite)
	);

endmodule

// ==== execStage_cfg.svh ====
`ifndef EXEC_STAGE_CFG_SVH
`define EXEC_STAGE_CFG_SVH

// datapath word
`define WORD_WIDTH 16

// eight architectural registers
`define REG_ADDR_WIDTH 3

// top four instruction bits followed by the two condition bits
`define OP_KEY_WIDTH 6

`endif

// ==== execStage_tb.sv ====
`include "execStage_cfg.svh"

module execStage_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// reset, six tests with a two-cycle drain each
	localparam int TEST_CYCLES = 2 + 10 + 48 + 48 + 48 + 32 + 64 + 6 * 2;

	logic              clk;
	logic              reset;
	logic              inValid;
	execPkg::opKey     op;
	execPkg::regAddr   regA;
	execPkg::regAddr   regB;
	execPkg::regAddr   regC;
	execPkg::word      rfData1;
	execPkg::word      rfData2;
	execPkg::word      imm;
	logic              exMemValid;
	execPkg::opKey     exMemOp;
	execPkg::regAddr   exMemRegA;
	execPkg::regAddr   exMemRegB;
	execPkg::regAddr   exMemRegC;
	logic              exMemExecuted;
	execPkg::word      exMemResult;
	logic              exMemFlagWrite;
	execPkg::condFlags exMemFlags;
	logic              memWbValid;
	execPkg::opKey     memWbOp;
	execPkg::regAddr   memWbRegA;
	execPkg::regAddr   memWbRegB;
	execPkg::regAddr   memWbRegC;
	logic              memWbExecuted;
	execPkg::word      memWbResult;
	logic              memWbFlagWrite;
	execPkg::condFlags memWbFlags;
	logic              ccrWrite;
	execPkg::condFlags ccrValue;
	logic              outValid;
	execPkg::word      result;
	execPkg::regAddr   destReg;
	logic              regWrite;
	execPkg::condFlags flags;
	logic              flagWrite;
	execPkg::condFlags ccr;

	// reference model state
	logic              expValid;
	logic              expRegWrite;
	logic              expFlagWrite;
	execPkg::word      expResult;
	execPkg::regAddr   expDest;
	execPkg::condFlags expFlags;
	execPkg::condFlags expCcr;
	execPkg::word      opnd1;
	execPkg::word      opnd2;
	int                wide;
	logic              isNand;
	logic              isAdi;
	logic              isRtype;
	execPkg::word      predResult;
	execPkg::condFlags predFlags;
	execPkg::condFlags seenFlags;
	logic              predCond;

	logic [31:0] lfsr = 32'h08ae6387;
	int          errors = 0;
	int          testStartErrors = 0;
	int          testsFailed = 0;

	execPkg::opKey condOps [4] = '{execPkg::ADC, execPkg::ADZ, execPkg::NDC, execPkg::NDZ};
	execPkg::opKey keptOps [8] = '{execPkg::ADD, execPkg::ADC, execPkg::ADZ, execPkg::NDU,
		execPkg::NDC, execPkg::NDZ, execPkg::ADI, execPkg::ADD};
	// every producer a later stage may hold, a few repeated to fill sixteen slots
	execPkg::opKey stageOps [16] = '{execPkg::ADD, execPkg::ADC, execPkg::ADZ, execPkg::NDU,
		execPkg::NDC, execPkg::NDZ, execPkg::ADI, execPkg::LHI, execPkg::LW, execPkg::SW,
		execPkg::LM, execPkg::JAL, execPkg::JLR, execPkg::ADD, execPkg::SW, execPkg::LW};

	execStage execStage_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// does a later stage forward into this source register
	function automatic logic stageHits(input logic valid, input logic executed,
		input execPkg::opKey k, input execPkg::regAddr ra, input execPkg::regAddr rb,
		input execPkg::regAddr rc, input execPkg::regAddr src);
		logic            writes;
		execPkg::regAddr d;
		writes = 1'b1;
		d = rc; // R-type
		if (k[5:2] == 4'b0001)
			d = rb;
		else if (k inside {execPkg::LHI, execPkg::LW, execPkg::LM, execPkg::JAL})
			d = ra;
		else if (!(k inside {execPkg::ADD, execPkg::ADC, execPkg::ADZ, execPkg::NDU,
			execPkg::NDC, execPkg::NDZ}))
			writes = 1'b0; // SW, JLR, unknown
		return valid && executed && writes && d == src;
	endfunction

	always_comb
	begin
		isNand  = op inside {execPkg::NDU, execPkg::NDC, execPkg::NDZ};
		isAdi   = (op[5:2] == 4'b0001);
		isRtype = op inside {execPkg::ADD, execPkg::ADC, execPkg::ADZ, execPkg::NDU,
			execPkg::NDC, execPkg::NDZ};
		if (stageHits(exMemValid, exMemExecuted, exMemOp, exMemRegA, exMemRegB, exMemRegC, regA))
			opnd1 = exMemResult;
		else if (stageHits(memWbValid, memWbExecuted, memWbOp, memWbRegA, memWbRegB, memWbRegC,
			regA))
			opnd1 = memWbResult;
		else
			opnd1 = rfData1;
		if (isAdi)
			opnd2 = imm;
		else if (isRtype && stageHits(exMemValid, exMemExecuted, exMemOp, exMemRegA, exMemRegB,
			exMemRegC, regB))
			opnd2 = exMemResult;
		else if (isRtype && stageHits(memWbValid, memWbExecuted, memWbOp, memWbRegA, memWbRegB,
			memWbRegC, regB))
			opnd2 = memWbResult;
		else
			opnd2 = rfData2;
		wide = int'(opnd1) + int'(opnd2);
		predResult = isNand ? ~(opnd1 & opnd2) : execPkg::word'(wide);
		predFlags.zero  = (predResult == '0);
		predFlags.carry = !isNand && wide >= (1 << `WORD_WIDTH); // sum overflows the word
		if (exMemValid && exMemFlagWrite)
			seenFlags = exMemFlags;
		else if (memWbValid && memWbFlagWrite)
			seenFlags = memWbFlags;
		else
			seenFlags = expCcr;
		if (op inside {execPkg::ADC, execPkg::NDC})
			predCond = seenFlags.carry;
		else if (op inside {execPkg::ADZ, execPkg::NDZ})
			predCond = seenFlags.zero;
		else
			predCond = 1'b1;
	end

	always @(posedge clk)
	begin
		if (!reset)
		begin
			expValid     <= 1'b0;
			expRegWrite  <= 1'b0;
			expFlagWrite <= 1'b0;
			expCcr       <= '0;
		end
		else
		begin
			expValid     <= inValid;
			expRegWrite  <= inValid && predCond;
			expFlagWrite <= inValid && predCond;
			if (ccrWrite)
				expCcr <= ccrValue;
		end
		if (inValid)
		begin
			expResult <= predResult;
			expFlags  <= predFlags;
			expDest   <= isAdi ? regB : regC;
		end
	end

	task automatic mismatch(input string sig, input logic [31:0] expv, input logic [31:0] actv);
		errors++;
		$display("MISMATCH at %.1f ns: %s expected %0h, got %0h", $realtime, sig, expv, actv);
	endtask

	checkValid: assert property (@(posedge clk) disable iff (!reset) outValid == expValid)
		else mismatch("outValid", 32'($sampled(expValid)), 32'($sampled(outValid)));
	checkRegWrite: assert property (@(posedge clk) disable iff (!reset) regWrite == expRegWrite)
		else mismatch("regWrite", 32'($sampled(expRegWrite)), 32'($sampled(regWrite)));
	checkFlagWrite: assert property (@(posedge clk) disable iff (!reset)
		flagWrite == expFlagWrite)
		else mismatch("flagWrite", 32'($sampled(expFlagWrite)), 32'($sampled(flagWrite)));
	checkCcr: assert property (@(posedge clk) disable iff (!reset) ccr == expCcr)
		else mismatch("ccr", 32'($sampled(expCcr)), 32'($sampled(ccr)));
	checkResult: assert property (@(posedge clk) disable iff (!reset)
		!expValid || result == expResult)
		else mismatch("result", 32'($sampled(expResult)), 32'($sampled(result)));
	checkDest: assert property (@(posedge clk) disable iff (!reset)
		!expValid || destReg == expDest)
		else mismatch("destReg", 32'($sampled(expDest)), 32'($sampled(destReg)));
	checkFlags: assert property (@(posedge clk) disable iff (!reset)
		!expValid || flags == expFlags)
		else mismatch("flags", 32'($sampled(expFlags)), 32'($sampled(flags)));

	task automatic idleStages();
		exMemValid = 1'b0;
		memWbValid = 1'b0;
		ccrWrite   = 1'b0;
	endtask

	task automatic randomStages(input int regBits);
		logic [31:0] r;
		takeBits(6, r);
		exMemValid     = r[5];
		exMemExecuted  = r[4];
		exMemFlagWrite = r[3];
		memWbValid     = r[2];
		memWbExecuted  = r[1];
		memWbFlagWrite = r[0];
		takeBits(4, r);
		exMemOp = stageOps[r[3:0]];
		takeBits(4, r);
		memWbOp = stageOps[r[3:0]];
		takeBits(regBits, r);
		exMemRegA = r[2:0];
		takeBits(regBits, r);
		exMemRegB = r[2:0];
		takeBits(regBits, r);
		exMemRegC = r[2:0];
		takeBits(regBits, r);
		memWbRegA = r[2:0];
		takeBits(regBits, r);
		memWbRegB = r[2:0];
		takeBits(regBits, r);
		memWbRegC = r[2:0];
		takeBits(`WORD_WIDTH, r);
		exMemResult = r[`WORD_WIDTH-1:0];
		takeBits(`WORD_WIDTH, r);
		memWbResult = r[`WORD_WIDTH-1:0];
		takeBits(4, r);
		exMemFlags = r[3:2];
		memWbFlags = r[1:0];
	endtask

	task automatic issue(input execPkg::opKey k, input int regBits, input logic valid);
		logic [31:0] r;
		op      = k;
		inValid = valid;
		takeBits(regBits, r);
		regA = r[2:0];
		takeBits(regBits, r);
		regB = r[2:0];
		takeBits(3, r);
		regC = r[2:0];
		takeBits(`WORD_WIDTH, r);
		rfData1 = r[`WORD_WIDTH-1:0];
		takeBits(`WORD_WIDTH, r);
		rfData2 = r[`WORD_WIDTH-1:0];
		takeBits(`WORD_WIDTH, r);
		imm = r[`WORD_WIDTH-1:0];
		takeBits(2, r);
		if (r[1:0] == 2'b00)
			rfData2 = -rfData1; // sum wraps to zero with carry
		else if (r[1:0] == 2'b01)
		begin
			rfData1 = '1; // nand of all ones is zero
			rfData2 = '1;
		end
	endtask

	task automatic finishTest(input string name);
		int failedNow;
		@(negedge clk);
		inValid = 1'b0;
		idleStages();
		@(negedge clk);
		failedNow = errors - testStartErrors;
		if (failedNow > 0)
			testsFailed++;
		$display("test %s finished with %0d mismatches", name, failedNow);
		testStartErrors = errors;
	endtask

	initial
	begin
		#((TEST_CYCLES + 100) * 4);
		$display("watchdog expired, the tests did not finish within %0d cycles", TEST_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		logic [31:0]   r;
		logic [31:0]   v;
		execPkg::opKey k;
		reset = 1'b0;
		inValid = 1'b0;
		op = execPkg::ADD;
		exMemOp = execPkg::ADD;
		memWbOp = execPkg::ADD;
		{regA, regB, regC, rfData1, rfData2, imm} = '0;
		{exMemRegA, exMemRegB, exMemRegC, exMemResult, exMemFlags} = '0;
		{memWbRegA, memWbRegB, memWbRegC, memWbResult, memWbFlags} = '0;
		{exMemExecuted, exMemFlagWrite, memWbExecuted, memWbFlagWrite} = '0;
		ccrValue = '0;
		idleStages();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;

		repeat (10) @(negedge clk); // no strobes at all
		finishTest("resetIdle");

		for (int i = 0; i < 48; i++)
		begin
			@(negedge clk);
			takeBits(4, r);
			takeBits(2, v);
			if (r[1:0] == 2'b00)
				k = execPkg::ADD;
			else if (r[1:0] == 2'b01)
				k = execPkg::NDU;
			else
				k = execPkg::opKey'({4'b0001, r[3:2]}); // ADI, low bits are immediate
			issue(k, 3, v[1:0] != 2'b00);
		end
		finishTest("noForward");

		for (int i = 0; i < 48; i++)
		begin
			@(negedge clk);
			randomStages(1); // narrow indices so both stages often hit
			takeBits(1, r);
			issue(r[0] ? execPkg::NDU : execPkg::ADD, 1, 1'b1);
		end
		finishTest("forwarding");

		for (int i = 0; i < 48; i++)
		begin
			@(negedge clk);
			randomStages(3);
			takeBits(3, r);
			ccrWrite = r[2];
			ccrValue = r[1:0];
			takeBits(2, r);
			issue(condOps[r[1:0]], 3, 1'b1);
		end
		finishTest("conditional");

		for (int i = 0; i < 16; i++)
		begin
			@(negedge clk);
			idleStages();
			inValid = 1'b0;
			ccrWrite = 1'b1;
			takeBits(2, r);
			ccrValue = r[1:0];
			@(negedge clk);
			ccrWrite = 1'b0;
			takeBits(2, r);
			issue(condOps[r[1:0]], 3, 1'b1); // flags come from the new ccr
		end
		finishTest("ccrUpdate");

		for (int i = 0; i < 64; i++)
		begin
			@(negedge clk);
			randomStages(2);
			takeBits(4, r);
			ccrWrite = (r[3:2] == 2'b00);
			ccrValue = r[1:0];
			takeBits(4, r);
			issue(keptOps[r[2:0]], 2, r[3]);
		end
		finishTest("mixed");

		$display("tests run 6, tests failed %0d, mismatches %0d", testsFailed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== flagUnit.sv ====
module flagUnit
(
	input  logic             clk,
	input  logic             reset,
	input  execPkg::opKey    op,
	input  logic             ccrWrite,
	input  execPkg::condFlags ccrValue,
	input  logic             exMemValid,
	input  logic             exMemFlagWrite,
	input  execPkg::condFlags exMemFlags,
	input  logic             memWbValid,
	input  logic             memWbFlagWrite,
	input  execPkg::condFlags memWbFlags,
	output execPkg::condFlags ccr,
	output logic             condMet
);

	execPkg::condFlags srcFlags;

	// architectural CCR, written back from the end of the pipe
	always_ff @(posedge clk)
	begin
		if (!reset)
			ccr <= '0;
		else if (ccrWrite)
			ccr <= ccrValue;
	end

	// freshest flags first
	always_comb
	begin
		if (exMemValid && exMemFlagWrite)
			srcFlags = exMemFlags;
		else if (memWbValid && memWbFlagWrite)
			srcFlags = memWbFlags;
		else
			srcFlags = ccr;
	end

	always_comb
	begin
		case (op)
			execPkg::ADC, execPkg::NDC:
				condMet = srcFlags.carry;
			execPkg::ADZ, execPkg::NDZ:
				condMet = srcFlags.zero;
			default:
				condMet = 1'b1; // unconditional ops always execute
		endcase
	end

endmodule

// ==== hazardUnit.sv ====
module hazardUnit
(
	input  execPkg::opKey   op,
	input  execPkg::regAddr regA,
	input  execPkg::regAddr regB,
	input  logic            exMemValid,
	input  logic            exMemExecuted,
	input  execPkg::opKey   exMemOp,
	input  execPkg::regAddr exMemRegA,
	input  execPkg::regAddr exMemRegB,
	input  execPkg::regAddr exMemRegC,
	input  logic            memWbValid,
	input  logic            memWbExecuted,
	input  execPkg::opKey   memWbOp,
	input  execPkg::regAddr memWbRegA,
	input  execPkg::regAddr memWbRegB,
	input  execPkg::regAddr memWbRegC,
	output execPkg::fwdSel  sel1,
	output execPkg::fwdSel  sel2,
	output logic            useImm
);

	execPkg::regAddr exMemDest;
	execPkg::regAddr memWbDest;
	logic            exMemWrites;
	logic            memWbWrites;
	logic            exMemLive;
	logic            memWbLive;
	logic            rType;

	destDecode exMemDecode
	(
		.op(exMemOp),
		.regA(exMemRegA),
		.regB(exMemRegB),
		.regC(exMemRegC),
		.dest(exMemDest),
		.writesReg(exMemWrites)
	);

	destDecode memWbDecode
	(
		.op(memWbOp),
		.regA(memWbRegA),
		.regB(memWbRegB),
		.regC(memWbRegC),
		.dest(memWbDest),
		.writesReg(memWbWrites)
	);

	assign exMemLive = exMemValid && exMemExecuted && exMemWrites; // squashed ops never forward
	assign memWbLive = memWbValid && memWbExecuted && memWbWrites;
	assign useImm    = ({op[5:2], 2'b00} == execPkg::ADI);
	assign rType     = op inside {execPkg::ADD, execPkg::ADC, execPkg::ADZ,
		execPkg::NDU, execPkg::NDC, execPkg::NDZ};

	always_comb
	begin
		sel1 = execPkg::fromReg;
		if (exMemLive && exMemDest == regA)
			sel1 = execPkg::fromExMem; // youngest producer wins
		else if (memWbLive && memWbDest == regA)
			sel1 = execPkg::fromMemWb;

		sel2 = execPkg::fromReg;
		if (rType && exMemLive && exMemDest == regB)
			sel2 = execPkg::fromExMem;
		else if (rType && memWbLive && memWbDest == regB)
			sel2 = execPkg::fromMemWb;
	end

endmodule

// ==== operandSelect.sv ====
module operandSelect
(
	input  execPkg::word   rfData1,
	input  execPkg::word   rfData2,
	input  execPkg::word   imm,
	input  execPkg::word   exMemResult,
	input  execPkg::word   memWbResult,
	input  execPkg::fwdSel sel1,
	input  execPkg::fwdSel sel2,
	input  logic           useImm,
	output execPkg::word   aluIn1,
	output execPkg::word   aluIn2
);

	// one forwarding mux, used for both inputs
	function automatic execPkg::word pick(execPkg::fwdSel sel, execPkg::word regData);
		case (sel)
			execPkg::fromExMem: return exMemResult;
			execPkg::fromMemWb: return memWbResult;
			default:            return regData;
		endcase
	endfunction

	always_comb
	begin
		aluIn1 = pick(sel1, rfData1);
		if (useImm)
			aluIn2 = imm; // ADI takes the sign-extended immediate
		else
			aluIn2 = pick(sel2, rfData2);
	end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 -f compile.f --top-module execStage_tb \
	-Mdir obj_dir -o execStage_sim
out=$(./obj_dir/execStage_sim)
echo "$out"
if echo "$out" | grep -q "^Everything OK$"; then
	exit 0
fi
exit 1
